/* azadi_boot_pkg.sv */
/*
  Shared widths, word and address types, boot vectors and PLL lock count
*/
package azadi_boot_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Instruction and data word width
  localparam int unsigned WORD_W = 32;

  // ICCM word address, 8192 words
  localparam int unsigned ICCM_AW = 13;

  typedef logic [WORD_W-1:0]  word_t;
  typedef logic [ICCM_AW-1:0] iccm_addr_t;

  //////////////////////////////////////////////////////////////////////
  // Boot vectors
  //////////////////////////////////////////////////////////////////////

  // On-chip ROM
  localparam word_t ROM_BOOT_ADDR  = 32'h0000_1000;

  // ICCM after a successful SPI load
  localparam word_t ICCM_BOOT_ADDR = 32'h2000_0000;

  // External QSPI flash
  localparam word_t QSPI_BOOT_ADDR = 32'h8000_0000;

  //////////////////////////////////////////////////////////////////////
  // Clock enable
  //////////////////////////////////////////////////////////////////////

  // Consecutive lock cycles before the main clock is released
  localparam int unsigned PLL_LOCK_CYCLES = 16;

  // Must be able to hold PLL_LOCK_CYCLES itself
  typedef logic [$clog2(PLL_LOCK_CYCLES+1)-1:0] lock_cnt_t;

endpackage

/* hk_spi_loader.sv */
/*
  Housekeeping SPI slave: pin synchronizers, word assembly,
  ICCM write strobe and program-done flag
*/
`timescale 1ns/1ps

module hk_spi_loader (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       hk_sck_i,
  input  logic                       hk_sdi_i,
  input  logic                       hk_csb_i,
  output logic                       hk_sdo_o,
  output logic                       prog_active_o,
  output logic                       iccm_we_o,
  output azadi_boot_pkg::iccm_addr_t iccm_waddr_o,
  output azadi_boot_pkg::word_t      iccm_wdata_o
);

  localparam int unsigned BitCntW = $clog2(azadi_boot_pkg::WORD_W);

  // Pins packed as {csb, sck, sdi}
  logic [2:0] pins_meta_q;
  logic [2:0] pins_sync_q;

  logic csb_sync;
  logic sck_sync;
  logic sdi_sync;

  // Previous synchronized levels for edge detection
  logic csb_q;
  logic sck_q;

  logic csb_fall;
  logic csb_rise;
  logic sck_rise;
  logic shift_en;
  logic word_full;

  logic [BitCntW-1:0]                 bit_cnt_q;
  logic [azadi_boot_pkg::WORD_W-2:0]  shift_q;
  azadi_boot_pkg::iccm_addr_t         addr_q;
  logic                               wrote_q;
  logic                               done_q;

  //////////////////////////////////////////////////////////////////////
  // Pin synchronizers
  //////////////////////////////////////////////////////////////////////

  // csb idles high so the reset value avoids a false session start
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pins_meta_q <= 3'b100;
      pins_sync_q <= 3'b100;
      csb_q       <= 1'b1;
      sck_q       <= 1'b0;
    end else begin
      pins_meta_q <= {hk_csb_i, hk_sck_i, hk_sdi_i};
      pins_sync_q <= pins_meta_q;
      csb_q       <= csb_sync;
      sck_q       <= sck_sync;
    end
  end

  assign csb_sync = pins_sync_q[2];
  assign sck_sync = pins_sync_q[1];
  assign sdi_sync = pins_sync_q[0];

  assign csb_fall = csb_q & ~csb_sync;
  assign csb_rise = ~csb_q & csb_sync;
  assign sck_rise = sck_sync & ~sck_q;

  // One bit per sck rise inside a session
  assign shift_en  = ~csb_sync & sck_rise;
  assign word_full = shift_en & (bit_cnt_q == '1);

  //////////////////////////////////////////////////////////////////////
  // Word assembly and session tracking
  //////////////////////////////////////////////////////////////////////

  // MSB first, the last bit goes straight to the write data
  always_ff @(posedge clk_i) begin
    if (shift_en) begin
      shift_q <= {shift_q[azadi_boot_pkg::WORD_W-3:0], sdi_sync};
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bit_cnt_q <= '0;
      addr_q    <= '0;
      wrote_q   <= 1'b0;
      done_q    <= 1'b0;
    end else if (csb_fall) begin
      // New session restarts at word 0
      bit_cnt_q <= '0;
      addr_q    <= '0;
      wrote_q   <= 1'b0;
      done_q    <= 1'b0;
    end else if (csb_rise) begin
      // Partial word is simply dropped
      done_q <= wrote_q;
    end else if (shift_en) begin
      bit_cnt_q <= bit_cnt_q + 1'b1;
      if (word_full) begin
        addr_q  <= addr_q + 1'b1;
        wrote_q <= 1'b1;
      end
    end
  end

  // Write strobe for one clock on the 32nd bit
  assign iccm_we_o    = word_full;
  assign iccm_waddr_o = addr_q;
  assign iccm_wdata_o = {shift_q, sdi_sync};

  assign prog_active_o = ~csb_sync;
  assign hk_sdo_o      = done_q;

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // Every written word moves the loader on to the next ICCM word
  assert property (@(posedge clk_i) disable iff (reset_i)
    iccm_we_o |=> (iccm_waddr_o == $past(iccm_waddr_o) + 1'b1))
    else $error("ICCM write address did not advance after a write");

endmodule

/* iccm_mem.sv */
/*
  Instruction memory, loader write port and registered fetch port
*/
`timescale 1ns/1ps

module iccm_mem (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       we_i,
  input  azadi_boot_pkg::iccm_addr_t waddr_i,
  input  azadi_boot_pkg::word_t      wdata_i,
  input  logic                       prog_active_i,
  input  logic                       fetch_req_i,
  input  azadi_boot_pkg::iccm_addr_t fetch_addr_i,
  output azadi_boot_pkg::word_t      fetch_rdata_o,
  output logic                       fetch_valid_o
);

  localparam int unsigned Depth = 1 << azadi_boot_pkg::ICCM_AW;

  azadi_boot_pkg::word_t mem_q [Depth];
  azadi_boot_pkg::word_t rdata_q;
  logic                  valid_q;

  //////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////

  // Loader is the only writer
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Fetch port
  //////////////////////////////////////////////////////////////////////

  // Read-before-write on a shared edge
  always_ff @(posedge clk_i) begin
    rdata_q <= mem_q[fetch_addr_i];
  end

  // Fetches are held off for the whole load
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= fetch_req_i & ~prog_active_i;
    end
  end

  assign fetch_rdata_o = rdata_q;
  assign fetch_valid_o = valid_q;

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // Writes only arrive while fetches are held off
  assert property (@(posedge clk_i) disable iff (reset_i)
    we_i |-> prog_active_i)
    else $error("ICCM written outside a programming session");

endmodule

/* boot_ctrl.sv */
/*
  PLL-lock clock-enable manager and registered boot address selection
*/
`timescale 1ns/1ps

module boot_ctrl (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  pll_lock_i,
  input  logic                  por_n_i,
  input  logic                  boot_sel_i,
  input  logic                  prog_done_i,
  output logic                  clk_enb_o,
  output azadi_boot_pkg::word_t boot_addr_o
);

  localparam azadi_boot_pkg::lock_cnt_t LockMax =
    azadi_boot_pkg::lock_cnt_t'(azadi_boot_pkg::PLL_LOCK_CYCLES);

  azadi_boot_pkg::lock_cnt_t lock_cnt_q;
  azadi_boot_pkg::word_t     boot_addr_q;

  //////////////////////////////////////////////////////////////////////
  // Clock enable
  //////////////////////////////////////////////////////////////////////

  // Counts consecutive lock cycles, saturates at LockMax
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_cnt_q <= '0;
    end else if (!pll_lock_i) begin
      // Any lock glitch restarts the wait
      lock_cnt_q <= '0;
    end else if (lock_cnt_q != LockMax) begin
      lock_cnt_q <= lock_cnt_q + 1'b1;
    end
  end

  // High only once the full count is reached
  assign clk_enb_o = (lock_cnt_q == LockMax);

  //////////////////////////////////////////////////////////////////////
  // Boot address
  //////////////////////////////////////////////////////////////////////

  // POR low forces ROM, then QSPI select, then a loaded ICCM
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      boot_addr_q <= azadi_boot_pkg::ROM_BOOT_ADDR;
    end else if (!por_n_i) begin
      boot_addr_q <= azadi_boot_pkg::ROM_BOOT_ADDR;
    end else if (boot_sel_i) begin
      boot_addr_q <= azadi_boot_pkg::QSPI_BOOT_ADDR;
    end else if (prog_done_i) begin
      boot_addr_q <= azadi_boot_pkg::ICCM_BOOT_ADDR;
    end else begin
      boot_addr_q <= azadi_boot_pkg::ROM_BOOT_ADDR;
    end
  end

  assign boot_addr_o = boot_addr_q;

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // Lock and strap levels are defined once out of reset
  assert property (@(posedge clk_i) disable iff (reset_i)
    !$isunknown({pll_lock_i, por_n_i, boot_sel_i, prog_done_i}))
    else $error("Unknown level on a boot control input");

endmodule

/* azadi_boot_top.sv */
/*
  Boot path top: SPI loader, ICCM and boot control
*/
`timescale 1ns/1ps

module azadi_boot_top (
  input  logic                       clk_main_i,
  input  logic                       reset_i,
  input  logic                       por_n_i,
  input  logic                       pll_lock_i,
  input  logic                       boot_sel_i,

  // Housekeeping SPI
  input  logic                       hk_sck_i,
  input  logic                       hk_sdi_i,
  input  logic                       hk_csb_i,
  output logic                       hk_sdo_o,

  // Fetch port for the external core
  input  logic                       fetch_req_i,
  input  azadi_boot_pkg::iccm_addr_t fetch_addr_i,
  output azadi_boot_pkg::word_t      fetch_rdata_o,
  output logic                       fetch_valid_o,

  output logic                       clk_enb_o,
  output azadi_boot_pkg::word_t      boot_addr_o
);

  // Loader to ICCM
  logic                       prog_active;
  logic                       iccm_we;
  azadi_boot_pkg::iccm_addr_t iccm_waddr;
  azadi_boot_pkg::word_t      iccm_wdata;

  hk_spi_loader u_hk_spi_loader (
    .clk_i         ( clk_main_i  ),
    .reset_i       ( reset_i     ),
    .hk_sck_i      ( hk_sck_i    ),
    .hk_sdi_i      ( hk_sdi_i    ),
    .hk_csb_i      ( hk_csb_i    ),
    .hk_sdo_o      ( hk_sdo_o    ),
    .prog_active_o ( prog_active ),
    .iccm_we_o     ( iccm_we     ),
    .iccm_waddr_o  ( iccm_waddr  ),
    .iccm_wdata_o  ( iccm_wdata  )
  );

  iccm_mem u_iccm_mem (
    .clk_i         ( clk_main_i    ),
    .reset_i       ( reset_i       ),
    .we_i          ( iccm_we       ),
    .waddr_i       ( iccm_waddr    ),
    .wdata_i       ( iccm_wdata    ),
    .prog_active_i ( prog_active   ),
    .fetch_req_i   ( fetch_req_i   ),
    .fetch_addr_i  ( fetch_addr_i  ),
    .fetch_rdata_o ( fetch_rdata_o ),
    .fetch_valid_o ( fetch_valid_o )
  );

  // Program-done doubles as the ICCM boot qualifier
  boot_ctrl u_boot_ctrl (
    .clk_i       ( clk_main_i  ),
    .reset_i     ( reset_i     ),
    .pll_lock_i  ( pll_lock_i  ),
    .por_n_i     ( por_n_i     ),
    .boot_sel_i  ( boot_sel_i  ),
    .prog_done_i ( hk_sdo_o    ),
    .clk_enb_o   ( clk_enb_o   ),
    .boot_addr_o ( boot_addr_o )
  );

endmodule

/* tb_azadi_boot.sv */
/*
  Testbench for the boot path top: clock and reset, LFSR stimulus,
  SPI load driver, boot address reference, compare tasks and timeout
*/
`timescale 1ns/1ps

module tb_azadi_boot;

  localparam int CLK_HALF     = 10;
  localparam int DRIVE_DLY    = 2;
  localparam int RESET_CYCLES = 5;
  localparam int SCK_HALF     = 4;
  localparam int NUM_WORDS    = 24;
  localparam int PARTIAL_BITS = 20;
  localparam int WORD_BITS    = azadi_boot_pkg::WORD_W;

  // Full load at 8 clocks per bit plus fixed overhead, with margin
  localparam int TIMEOUT_CYCLES = 3 * (NUM_WORDS * 32 * 8 + 2000);

  logic clk;
  logic reset;
  logic por_n;
  logic pll_lock;
  logic boot_sel;
  logic hk_sck;
  logic hk_sdi;
  logic hk_csb;
  logic hk_sdo;
  logic fetch_req;
  logic fetch_valid;
  logic clk_enb;

  azadi_boot_pkg::iccm_addr_t fetch_addr;
  azadi_boot_pkg::word_t      fetch_rdata;
  azadi_boot_pkg::word_t      boot_addr;

  // Words written by the full load, indexed by ICCM address
  azadi_boot_pkg::word_t exp_mem [NUM_WORDS];

  logic [31:0] lfsr_q;
  int          cycle_cnt;

  azadi_boot_top UUT (
    .clk_main_i    ( clk         ),
    .reset_i       ( reset       ),
    .por_n_i       ( por_n       ),
    .pll_lock_i    ( pll_lock    ),
    .boot_sel_i    ( boot_sel    ),
    .hk_sck_i      ( hk_sck      ),
    .hk_sdi_i      ( hk_sdi      ),
    .hk_csb_i      ( hk_csb      ),
    .hk_sdo_o      ( hk_sdo      ),
    .fetch_req_i   ( fetch_req   ),
    .fetch_addr_i  ( fetch_addr  ),
    .fetch_rdata_o ( fetch_rdata ),
    .fetch_valid_o ( fetch_valid ),
    .clk_enb_o     ( clk_enb     ),
    .boot_addr_o   ( boot_addr   )
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Failure handling and timeout
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("=== FAIL ===");
    $fatal(1, "%s", why);
  endtask

  initial cycle_cnt = 0;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      abort_run("simulation timed out");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic rand_bits(input int n, output azadi_boot_pkg::word_t val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[WORD_BITS-2:0], lfsr_q[0]};
    end
  endtask

  // Returns just after the edge, where inputs are driven
  task automatic step_clk();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic wait_clks(input int n);
    for (int i = 0; i < n; i++) begin
      step_clk();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model and compare tasks
  //////////////////////////////////////////////////////////////////////

  function automatic azadi_boot_pkg::word_t expected_boot_addr(
    input logic por_n_v,
    input logic sel_v,
    input logic done_v
  );
    if (!por_n_v) begin
      return azadi_boot_pkg::ROM_BOOT_ADDR;
    end else if (sel_v) begin
      return azadi_boot_pkg::QSPI_BOOT_ADDR;
    end else if (done_v) begin
      return azadi_boot_pkg::ICCM_BOOT_ADDR;
    end else begin
      return azadi_boot_pkg::ROM_BOOT_ADDR;
    end
  endfunction

  task automatic check_word(input string name, input azadi_boot_pkg::word_t exp,
                            input azadi_boot_pkg::word_t act);
    if (act !== exp) begin
      $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      abort_run("fetch data mismatch");
    end
  endtask

  task automatic check_boot(input azadi_boot_pkg::word_t exp,
                            input azadi_boot_pkg::word_t act);
    if (act !== exp) begin
      $display("Error at %0t: boot_addr_o expected %h, got %h", $time, exp, act);
      abort_run("boot address mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
      abort_run("status bit mismatch");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // SPI driver and fetch port
  //////////////////////////////////////////////////////////////////////

  // Data settles while sck is low, sampled on the rise
  task automatic spi_bit(input logic b);
    hk_sdi = b;
    hk_sck = 1'b0;
    wait_clks(SCK_HALF);
    hk_sck = 1'b1;
    wait_clks(SCK_HALF);
  endtask

  // Result is on the outputs when this returns
  task automatic do_fetch(input azadi_boot_pkg::iccm_addr_t addr);
    fetch_req  = 1'b1;
    fetch_addr = addr;
    step_clk();
    fetch_req  = 1'b0;
  endtask

  // Opens a session and probes the fetch port once it is blocked
  task automatic open_session();
    azadi_boot_pkg::word_t a;
    hk_csb = 1'b0;
    wait_clks(4);
    rand_bits(azadi_boot_pkg::ICCM_AW, a);
    do_fetch(a[azadi_boot_pkg::ICCM_AW-1:0]);
    check_bit("fetch_valid_o", 1'b0, fetch_valid);
  endtask

  task automatic close_session();
    hk_sck = 1'b0;
    wait_clks(SCK_HALF);
    hk_csb = 1'b1;
  endtask

  task automatic wait_for_sdo(input int max_clks);
    int n;
    n = 0;
    while (hk_sdo !== 1'b1 && n < max_clks) begin
      step_clk();
      n++;
    end
    check_bit("hk_sdo_o", 1'b1, hk_sdo);
  endtask

  task automatic load_program();
    azadi_boot_pkg::word_t w;
    open_session();
    for (int i = 0; i < NUM_WORDS; i++) begin
      rand_bits(WORD_BITS, w);
      exp_mem[i] = w;
      for (int b = WORD_BITS - 1; b >= 0; b--) begin
        spi_bit(w[b]);
      end
    end
    close_session();
    wait_for_sdo(8);
  endtask

  // Too few bits for a word, so nothing may be written
  task automatic partial_session();
    azadi_boot_pkg::word_t w;
    open_session();
    rand_bits(PARTIAL_BITS, w);
    for (int b = PARTIAL_BITS - 1; b >= 0; b--) begin
      spi_bit(w[b]);
    end
    close_session();
    wait_clks(8);
    check_bit("hk_sdo_o", 1'b0, hk_sdo);
  endtask

  task automatic fetch_all_words();
    for (int i = 0; i < NUM_WORDS; i++) begin
      do_fetch(azadi_boot_pkg::iccm_addr_t'(i));
      check_bit("fetch_valid_o", 1'b1, fetch_valid);
      check_word("fetch_rdata_o", exp_mem[i], fetch_rdata);
    end
  endtask

  task automatic boot_sweep(input logic done);
    for (int p = 0; p < 2; p++) begin
      for (int s = 0; s < 2; s++) begin
        por_n    = p[0];
        boot_sel = s[0];
        step_clk();
        check_boot(expected_boot_addr(p[0], s[0], done), boot_addr);
      end
    end
    por_n    = 1'b1;
    boot_sel = 1'b0;
  endtask

  task automatic check_clock_enable();
    pll_lock = 1'b1;
    for (int i = 1; i < azadi_boot_pkg::PLL_LOCK_CYCLES; i++) begin
      step_clk();
      check_bit("clk_enb_o", 1'b0, clk_enb);
    end
    step_clk();
    check_bit("clk_enb_o", 1'b1, clk_enb);
    pll_lock = 1'b0;
    step_clk();
    check_bit("clk_enb_o", 1'b0, clk_enb);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    lfsr_q     = 32'h55e6_e334;
    reset      = 1'b1;
    por_n      = 1'b0;
    pll_lock   = 1'b0;
    boot_sel   = 1'b0;
    hk_sck     = 1'b0;
    hk_sdi     = 1'b0;
    hk_csb     = 1'b1;
    fetch_req  = 1'b0;
    fetch_addr = '0;

    wait_clks(RESET_CYCLES);
    reset = 1'b0;
    check_bit("hk_sdo_o", 1'b0, hk_sdo);
    check_bit("fetch_valid_o", 1'b0, fetch_valid);
    check_bit("clk_enb_o", 1'b0, clk_enb);
    check_boot(azadi_boot_pkg::ROM_BOOT_ADDR, boot_addr);

    por_n = 1'b1;
    check_clock_enable();
    boot_sweep(1'b0);

    load_program();
    fetch_all_words();
    boot_sweep(1'b1);

    // A short session clears program-done but keeps the loaded image
    partial_session();
    fetch_all_words();
    boot_sweep(1'b0);

    $display("=== PASS ===");
    $finish;
  end

endmodule

/* build.f */
azadi_boot_pkg.sv
hk_spi_loader.sv
iccm_mem.sv
boot_ctrl.sv
azadi_boot_top.sv
tb_azadi_boot.sv

/* run.sh */
#!/usr/bin/env bash
# Build the boot path testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f build.f \
  --top-module tb_azadi_boot \
  -o sim_azadi_boot

./obj_dir/sim_azadi_boot
